/* hw/pkt_settings.svh */
`ifndef PKT_SETTINGS_SVH
`define PKT_SETTINGS_SVH

// Width of one FIFO data word
`define PKT_DATA_WIDTH 32

// Number of switch ports, sets the dest and source port field width
`define PKT_PORT_TOTAL 16

// Number of priority levels, sets the priority field width
`define PKT_PRIORITY_LEVELS 4

// Length field range; legal lengths are 1 to PKT_LENGTH_MAX-1
`define PKT_LENGTH_MAX 64

// FIFO depth in words, at least two maximum packets
`define PKT_FIFO_DEPTH 128

`endif

/* hw/pkt_pkg.sv */
`include "pkt_settings.svh"

package pkt_pkg;

    typedef logic [`PKT_DATA_WIDTH-1:0] pkt_data_t;
    typedef logic [$clog2(`PKT_PORT_TOTAL)-1:0] pkt_port_t;
    typedef logic [$clog2(`PKT_PRIORITY_LEVELS)-1:0] pkt_prio_t;
    typedef logic [$clog2(`PKT_LENGTH_MAX)-1:0] pkt_len_t;

    // Low bits of the header word, upper bits are zero
    typedef struct packed {
        pkt_port_t dest;
        pkt_prio_t prio;
        pkt_len_t  length;
    } pkt_header_t;

    // One FIFO entry
    typedef struct packed {
        logic      sop;
        logic      eop;
        pkt_data_t data;
    } pkt_word_t;

    // Report for the last packet the sink finished
    typedef struct packed {
        pkt_port_t   src_port;
        pkt_header_t header;
        logic        error;
    } pkt_status_t;

endpackage

/* hw/packet_source.sv */
module packet_source import pkt_pkg::*; #(
    parameter pkt_port_t tx_port = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  pkt_port_t dest,
    input  pkt_prio_t prio,
    input  pkt_len_t  length,
    input  logic      room,
    output logic      ready,
    output logic      done,
    output logic      wr_vld,
    output pkt_word_t wr_word
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_SEND,
        ST_DONE
    } src_state_t;

    src_state_t  state;
    pkt_header_t hdr_q;
    pkt_len_t    idx;
    logic        accept;
    logic        last;

    assign ready  = (state == ST_IDLE) && room;
    assign accept = ready && start;
    assign last   = (idx == hdr_q.length - pkt_len_t'(1));
    assign done   = (state == ST_DONE);
    assign wr_vld = (state == ST_HEADER) || (state == ST_SEND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    idx <= '0;
                    if (accept) begin
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    state <= ST_SEND;
                end
                ST_SEND: begin
                    idx <= idx + pkt_len_t'(1);
                    if (last) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (!start) begin  // Wait for the start strobe to drop
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hdr_q <= '{dest: dest, prio: prio, length: length};
        end
    end

    always_comb begin
        wr_word = '0;
        case (state)
            ST_HEADER: begin
                wr_word.sop  = 1'b1;
                wr_word.data = pkt_data_t'(hdr_q);
            end
            ST_SEND: begin
                wr_word.eop  = last;
                wr_word.data = {tx_port, hdr_q.dest, 24'(idx)};  // Port, dest, running index
            end
            default: ;
        endcase
    end

    a_length_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n) accept |-> (length != '0)
    );

    a_quiet_after_eop: assert property (
        @(posedge clk) disable iff (!rst_n) (wr_vld && wr_word.eop) |=> !wr_vld
    );

endmodule

/* hw/packet_fifo.sv */
`include "pkt_settings.svh"

module packet_fifo import pkt_pkg::*; #(
    parameter type word_t = pkt_word_t
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  word_t push_word,
    input  logic  pop,
    output word_t head_word,
    output logic  empty,
    output logic  room
);

    localparam int DEPTH = `PKT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    localparam logic [PTR_W:0]   FILL_MAX = (PTR_W + 1)'(DEPTH);
    localparam logic [PTR_W:0]   ROOM_MIN = (PTR_W + 1)'(`PKT_LENGTH_MAX);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    word_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    logic             full;

    assign head_word = mem[rd_ptr];  // Show-ahead read of the oldest entry
    assign empty     = (fill == '0);
    assign full      = (fill == FILL_MAX);
    assign room      = (FILL_MAX - fill) >= ROOM_MIN;  // Space for one whole packet

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) full |-> !push
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n) empty |-> !pop
    );

endmodule

/* hw/packet_sink.sv */
module packet_sink import pkt_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hold,
    input  pkt_word_t   head_word,
    input  logic        empty,
    output logic        pop,
    output logic        pkt_done,
    output pkt_status_t status,
    output logic [15:0] good_count,
    output logic [15:0] bad_count
);

    pkt_header_t hdr_q;
    logic [23:0] idx_q;
    pkt_port_t   src_q;
    logic        in_pkt_q;
    logic        err_q;

    pkt_port_t   word_src;
    pkt_port_t   word_dest;
    logic [23:0] word_idx;
    pkt_port_t   src_now;
    logic        word_bad;
    logic        pkt_bad;

    assign pop = !empty && !hold;

    assign word_src  = head_word.data[31:28];
    assign word_dest = head_word.data[27:24];
    assign word_idx  = head_word.data[23:0];

    // First payload word carries the source port for the whole packet
    assign src_now = (idx_q == '0) ? word_src : src_q;

    assign word_bad = !in_pkt_q || (word_dest != hdr_q.dest) || (word_idx != idx_q);
    assign pkt_bad  = err_q || word_bad || (idx_q != 24'(hdr_q.length) - 24'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_q      <= '0;
            idx_q      <= '0;
            src_q      <= '0;
            in_pkt_q   <= 1'b0;
            err_q      <= 1'b0;
            pkt_done   <= 1'b0;
            status     <= '0;
            good_count <= '0;
            bad_count  <= '0;
        end else begin
            pkt_done <= 1'b0;
            if (pop) begin
                if (head_word.sop) begin
                    hdr_q    <= pkt_header_t'(head_word.data[$bits(pkt_header_t)-1:0]);
                    idx_q    <= '0;
                    in_pkt_q <= 1'b1;
                    err_q    <= 1'b0;
                end else begin
                    idx_q <= idx_q + 24'd1;
                    err_q <= err_q || word_bad;  // Sticky until the next header
                    if (idx_q == '0) begin
                        src_q <= word_src;
                    end
                    if (head_word.eop) begin
                        in_pkt_q <= 1'b0;
                        pkt_done <= 1'b1;
                        status   <= '{src_port: src_now, header: hdr_q, error: pkt_bad};
                        if (pkt_bad) begin
                            bad_count <= bad_count + 16'd1;
                        end else begin
                            good_count <= good_count + 16'd1;
                        end
                    end
                end
            end
        end
    end

    // Every packet has a header, so two eop words never pop back to back
    a_done_single: assert property (
        @(posedge clk) disable iff (!rst_n) pkt_done |=> !pkt_done
    );

endmodule

/* hw/packet_loop_top.sv */
module packet_loop_top import pkt_pkg::*; #(
    parameter pkt_port_t tx_port = '0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  pkt_port_t   dest,
    input  pkt_prio_t   prio,
    input  pkt_len_t    length,
    input  logic        hold,
    output logic        ready,
    output logic        done,
    output logic        pkt_done,
    output pkt_status_t status,
    output logic [15:0] good_count,
    output logic [15:0] bad_count
);

    logic      wr_vld;
    pkt_word_t wr_word;
    logic      room;
    pkt_word_t head_word;
    logic      empty;
    logic      pop;

    packet_source #(
        .tx_port(tx_port)
    ) packet_source_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .dest   (dest),
        .prio   (prio),
        .length (length),
        .room   (room),
        .ready  (ready),
        .done   (done),
        .wr_vld (wr_vld),
        .wr_word(wr_word)
    );

    packet_fifo #(
        .word_t(pkt_word_t)
    ) packet_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (wr_vld),
        .push_word(wr_word),
        .pop      (pop),
        .head_word(head_word),
        .empty    (empty),
        .room     (room)
    );

    packet_sink packet_sink_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (hold),
        .head_word (head_word),
        .empty     (empty),
        .pop       (pop),
        .pkt_done  (pkt_done),
        .status    (status),
        .good_count(good_count),
        .bad_count (bad_count)
    );

endmodule

/* testbench/packet_loop_tb.sv */
`include "pkt_settings.svh"

module packet_loop_tb import pkt_pkg::*;;

    localparam pkt_port_t TX_PORT = 4'd5;
    localparam int TIMEOUT_CYCLES = 5000;  // About 25 packets of up to 66 cycles, hold time and margin
    localparam int HOLD_LEN = 20;

    logic        clk;
    logic        rst_n;
    logic        start;
    pkt_port_t   dest;
    pkt_prio_t   prio;
    pkt_len_t    length;
    logic        hold;
    logic        ready;
    logic        done;
    logic        pkt_done;
    pkt_status_t status;
    logic [15:0] good_count;
    logic [15:0] bad_count;

    pkt_status_t exp_q[$];
    pkt_status_t got_q[$];
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    packet_loop_top #(
        .tx_port(TX_PORT)
    ) packet_loop_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .dest      (dest),
        .prio      (prio),
        .length    (length),
        .hold      (hold),
        .ready     (ready),
        .done      (done),
        .pkt_done  (pkt_done),
        .status    (status),
        .good_count(good_count),
        .bad_count (bad_count)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && pkt_done) begin
            got_q.push_back(status);  // Status is stable half a cycle after the edge
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    // Starts one packet as soon as ready allows and returns the cycles until done
    task automatic send_packet(input pkt_port_t d, input pkt_prio_t p, input pkt_len_t l,
                               input bit keep_start, output int done_cycles);
        pkt_status_t expected;
        while (!ready) @(negedge clk);
        start  = 1'b1;
        dest   = d;
        prio   = p;
        length = l;
        expected.src_port = TX_PORT;
        expected.header   = '{dest: d, prio: p, length: l};
        expected.error    = 1'b0;
        exp_q.push_back(expected);
        @(negedge clk);
        done_cycles = 1;
        while (!done) begin
            @(negedge clk);
            done_cycles++;
        end
        if (!keep_start) begin
            start = 1'b0;
        end
    endtask

    task automatic drain_and_compare();
        pkt_status_t exp_s;
        pkt_status_t got_s;
        while (got_q.size() < exp_q.size()) @(negedge clk);
        repeat (2) @(negedge clk);  // Catch any extra pkt_done
        check_value("pkt_done count", exp_q.size(), got_q.size());
        while (exp_q.size() > 0 && got_q.size() > 0) begin
            exp_s = exp_q.pop_front();
            got_s = got_q.pop_front();
            check_value("status.src_port", exp_s.src_port, got_s.src_port);
            check_value("status.header", exp_s.header, got_s.header);
            check_value("status.error", exp_s.error, got_s.error);
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        check_value("ready", 1, ready);
        check_value("done", 0, done);
        check_value("pkt_done", 0, pkt_done);
        check_value("good_count", 0, good_count);
        check_value("bad_count", 0, bad_count);
        finish_test("reset_state", e0);
    endtask

    task automatic test_single_packet();
        int e0;
        int cycles;
        e0 = errors;
        send_packet(4'd3, 2'd2, 6'd5, 1'b0, cycles);
        check_value("done latency", 5 + 2, cycles);  // Header, five payload cycles, then done
        drain_and_compare();
        check_value("good_count", 1, good_count);
        finish_test("single_packet", e0);
    endtask

    task automatic test_done_handshake();
        int e0;
        int cycles;
        e0 = errors;
        send_packet(4'd9, 2'd1, 6'd3, 1'b1, cycles);
        repeat (5) begin
            @(negedge clk);
            check_value("done", 1, done);
            check_value("ready", 0, ready);
        end
        start = 1'b0;
        @(negedge clk);
        check_value("ready", 1, ready);
        check_value("done", 0, done);
        drain_and_compare();
        finish_test("done_handshake", e0);
    endtask

    task automatic test_random_stream();
        int e0;
        int cycles;
        logic [15:0] good_base;
        e0 = errors;
        good_base = good_count;
        repeat (20) begin
            send_packet(pkt_port_t'($urandom_range(15, 0)), pkt_prio_t'($urandom_range(3, 0)),
                        pkt_len_t'($urandom_range(63, 1)), 1'b0, cycles);
        end
        drain_and_compare();
        check_value("good_count delta", 20, good_count - good_base);
        check_value("bad_count", 0, bad_count);
        finish_test("random_stream", e0);
    endtask

    task automatic test_back_pressure();
        int e0;
        int cycles;
        int accepted;
        int waited;
        int max_fit;
        e0 = errors;
        accepted = 0;
        max_fit = `PKT_FIFO_DEPTH / (HOLD_LEN + 1);
        hold = 1'b1;
        forever begin
            waited = 0;
            while (!ready && waited < 10) begin
                @(negedge clk);
                waited++;
            end
            if (!ready || accepted > max_fit) begin
                break;  // Ready stayed low, the FIFO has no room for another packet
            end
            send_packet(pkt_port_t'(accepted), 2'd3, pkt_len_t'(HOLD_LEN), 1'b0, cycles);
            accepted++;
        end
        check_true(accepted >= 1, "no packet was accepted while hold was high");
        check_true(accepted <= max_fit, "more packets accepted than fit in the FIFO");
        check_value("pkt_done count under hold", 0, got_q.size());
        hold = 1'b0;
        drain_and_compare();
        check_value("bad_count", 0, bad_count);
        finish_test("back_pressure", e0);
    endtask

    task automatic test_boundary_lengths();
        int e0;
        int cycles;
        e0 = errors;
        send_packet(4'd14, 2'd0, 6'd1, 1'b0, cycles);
        check_value("done latency", 1 + 2, cycles);
        send_packet(4'd1, 2'd3, 6'd63, 1'b0, cycles);
        check_value("done latency", 63 + 2, cycles);
        drain_and_compare();
        check_value("bad_count", 0, bad_count);
        finish_test("boundary_lengths", e0);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        dest         = '0;
        prio         = '0;
        length       = '0;
        hold         = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;
        void'($urandom(32'h4742));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_single_packet();
        test_done_handshake();
        test_random_stream();
        test_back_pressure();
        test_boundary_lengths();

        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/pkt_pkg.sv
hw/packet_source.sv
hw/packet_fifo.sv
hw/packet_sink.sv
hw/packet_loop_top.sv
testbench/packet_loop_tb.sv
